// ==== hw/issue_pkg.sv ====
package issue_pkg;

  // Sizing
  localparam int TAG_WIDTH   = 6;                 // 64 physical tags
  localparam int ALU_ENTRIES = 4;                 // ALU bank depth
  localparam int MUL_ENTRIES = 2;                 // Multiply bank depth

  // Physical register tag
  typedef logic [TAG_WIDTH-1:0] tag_t;

  // Functional unit class
  typedef enum logic {
    FU_ALU = 1'b0,                                // Simple integer ops
    FU_MUL = 1'b1                                 // Multiplier ops
  } fu_t;

  // ALU opcodes
  typedef enum logic [2:0] {
    ADD = 3'd0,                                   // Also the idle value on issue
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLT = 3'd5,                                   // Signed compare
    SLL = 3'd6,
    SRL = 3'd7
  } alu_op_t;

  // Multiply opcodes
  typedef enum logic [1:0] {
    MUL    = 2'd0,                                // Low half, idle value on issue
    MULH   = 2'd1,                                // High half signed x signed
    MULHU  = 2'd2,                                // High half unsigned x unsigned
    MULHSU = 2'd3                                 // High half signed x unsigned
  } mul_op_t;

endpackage

// ==== hw/rs_bank.sv ====
`timescale 1ns/1ps

module rs_bank #(
  parameter type            payload_t = logic [2:0],       // Opcode type held per entry
  parameter int             ENTRIES   = 4,                 // Entry count
  parameter issue_pkg::fu_t BANK_FU   = issue_pkg::FU_ALU  // Class this bank accepts
) (
  input  logic              clock,
  input  logic              reset,
  // Dispatch side
  input  logic              dispatch_valid,
  input  issue_pkg::fu_t    dispatch_fu,
  output logic              bank_dispatch_ready,
  input  issue_pkg::tag_t   dispatch_tag,
  input  issue_pkg::tag_t   dispatch_src1_tag,
  input  issue_pkg::tag_t   dispatch_src2_tag,
  input  logic              dispatch_src1_ready,
  input  logic              dispatch_src2_ready,
  input  payload_t          dispatch_payload,
  // Completion broadcast
  input  logic              cdb_valid,
  input  issue_pkg::tag_t   cdb_tag,
  // Request toward the selector
  output logic              req_valid,
  output issue_pkg::tag_t   req_tag,
  output issue_pkg::tag_t   req_src1_tag,
  output issue_pkg::tag_t   req_src2_tag,
  output payload_t          req_payload,
  input  logic              grant
);

  import issue_pkg::*;

  // Entry storage
  logic [ENTRIES-1:0] busy;                      // Entry holds a waiting instruction
  logic [ENTRIES-1:0] src1_rdy;                  // Source 1 value available
  logic [ENTRIES-1:0] src2_rdy;                  // Source 2 value available
  tag_t               entry_tag  [ENTRIES];      // Destination tag
  tag_t               entry_src1 [ENTRIES];      // Source 1 tag
  tag_t               entry_src2 [ENTRIES];      // Source 2 tag
  payload_t           entry_payload [ENTRIES];   // Opcode

  // Wakeup and selection
  logic [ENTRIES-1:0] wake1;                     // CDB hits source 1 this cycle
  logic [ENTRIES-1:0] wake2;                     // CDB hits source 2 this cycle
  logic [ENTRIES-1:0] ready_mask;                // Busy with both sources ready
  logic [ENTRIES-1:0] pick_sel;                  // Lowest ready entry, one-hot
  logic [ENTRIES-1:0] lock_sel;                  // Entry held under back-pressure
  logic [ENTRIES-1:0] req_sel;                   // Entry currently offered
  logic [ENTRIES-1:0] free_mask;                 // Not busy at cycle start
  logic [ENTRIES-1:0] fill_sel;                  // Lowest free entry, one-hot
  logic [ENTRIES-1:0] busy_next;
  logic               accept;                    // Dispatch lands here this edge
  logic               disp_wake1;                // Broadcast during dispatch
  logic               disp_wake2;

  // CDB compare per entry, each source against its own tag
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      wake1[i]      = cdb_valid && (entry_src1[i] == cdb_tag);
      wake2[i]      = cdb_valid && (entry_src2[i] == cdb_tag);
      ready_mask[i] = busy[i] && (src1_rdy[i] || wake1[i]) && (src2_rdy[i] || wake2[i]);
    end
  end

  assign pick_sel  = ready_mask & (~ready_mask + 1'b1);  // Isolate lowest set bit
  assign req_sel   = (|lock_sel) ? lock_sel : pick_sel;  // Locked entry keeps the port
  assign req_valid = |req_sel;

  // One-hot mux of the offered entry
  always_comb begin
    req_tag      = '0;
    req_src1_tag = '0;
    req_src2_tag = '0;
    req_payload  = payload_t'('0);
    for (int i = 0; i < ENTRIES; i++) begin
      if (req_sel[i]) begin
        req_tag      = entry_tag[i];
        req_src1_tag = entry_src1[i];
        req_src2_tag = entry_src2[i];
        req_payload  = entry_payload[i];
      end
    end
  end

  // Dispatch acceptance
  assign free_mask           = ~busy;
  assign fill_sel            = free_mask & (~free_mask + 1'b1);  // Lowest free entry
  assign bank_dispatch_ready = (dispatch_fu == BANK_FU) && (|free_mask);
  assign accept              = dispatch_valid && bank_dispatch_ready;
  assign disp_wake1          = cdb_valid && (dispatch_src1_tag == cdb_tag);
  assign disp_wake2          = cdb_valid && (dispatch_src2_tag == cdb_tag);

  // Granted entry leaves, accepted dispatch arrives
  always_comb begin
    busy_next = busy;
    if (grant) begin
      busy_next = busy_next & ~req_sel;
    end
    if (accept) begin
      busy_next = busy_next | fill_sel;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= '0;
      lock_sel <= '0;
    end else begin
      busy     <= busy_next;
      lock_sel <= (req_valid && !grant) ? req_sel : '0;  // Hold choice until granted
    end
  end

  // Entry contents
  always_ff @(posedge clock) begin
    for (int i = 0; i < ENTRIES; i++) begin
      if (accept && fill_sel[i]) begin
        entry_tag[i]     <= dispatch_tag;
        entry_src1[i]    <= dispatch_src1_tag;
        entry_src2[i]    <= dispatch_src2_tag;
        entry_payload[i] <= dispatch_payload;
        src1_rdy[i]      <= dispatch_src1_ready || disp_wake1;  // Same-cycle broadcast counts
        src2_rdy[i]      <= dispatch_src2_ready || disp_wake2;
      end else begin
        if (wake1[i]) begin
          src1_rdy[i] <= 1'b1;
        end
        if (wake2[i]) begin
          src2_rdy[i] <= 1'b1;
        end
      end
    end
  end

  // Selector only grants what we offer
  a_grant_needs_req: assert property (@(posedge clock) disable iff (reset)
    grant |-> req_valid);

  // Locked entry is never dropped
  a_lock_busy: assert property (@(posedge clock) disable iff (reset)
    (|lock_sel) |-> (|(lock_sel & busy)));

  // Request fields hold under back-pressure
  a_req_stable: assert property (@(posedge clock) disable iff (reset)
    (req_valid && !grant) |=> (req_valid && $stable(req_tag) && $stable(req_src1_tag)
                               && $stable(req_src2_tag) && $stable(req_payload)));

endmodule

// ==== hw/issue_select.sv ====
`timescale 1ns/1ps

module issue_select (
  input  logic                clock,
  input  logic                reset,
  // ALU bank request
  input  logic                alu_req_valid,
  input  issue_pkg::tag_t     alu_req_tag,
  input  issue_pkg::tag_t     alu_req_src1_tag,
  input  issue_pkg::tag_t     alu_req_src2_tag,
  input  issue_pkg::alu_op_t  alu_req_op,
  // Multiply bank request
  input  logic                mul_req_valid,
  input  issue_pkg::tag_t     mul_req_tag,
  input  issue_pkg::tag_t     mul_req_src1_tag,
  input  issue_pkg::tag_t     mul_req_src2_tag,
  input  issue_pkg::mul_op_t  mul_req_op,
  // Grants back to banks
  output logic                alu_grant,
  output logic                mul_grant,
  // Issue port
  output logic                issue_valid,
  input  logic                issue_ready,
  output issue_pkg::fu_t      issue_fu,
  output issue_pkg::tag_t     issue_tag,
  output issue_pkg::tag_t     issue_src1_tag,
  output issue_pkg::tag_t     issue_src2_tag,
  output issue_pkg::alu_op_t  issue_alu_op,
  output issue_pkg::mul_op_t  issue_mul_op
);

  import issue_pkg::*;

  logic prio_mul;       // Multiply bank wins the next tie
  logic hold;           // Port stalled last cycle
  logic hold_mul;       // Winner of the stalled cycle
  logic pick_mul;       // Current winner is the multiply bank
  logic transfer;       // Issue handshake completes

  // Winner choice
  always_comb begin
    if (hold) begin
      pick_mul = hold_mul;                            // Keep stalled winner
    end else if (alu_req_valid && mul_req_valid) begin
      pick_mul = prio_mul;                            // Tie goes to last loser
    end else begin
      pick_mul = mul_req_valid;
    end
  end

  assign issue_valid = alu_req_valid || mul_req_valid;
  assign transfer    = issue_valid && issue_ready;
  assign alu_grant   = transfer && !pick_mul;
  assign mul_grant   = transfer && pick_mul;

  // Field mux, other class opcode zeroed
  assign issue_fu       = pick_mul ? FU_MUL : FU_ALU;
  assign issue_tag      = pick_mul ? mul_req_tag      : alu_req_tag;
  assign issue_src1_tag = pick_mul ? mul_req_src1_tag : alu_req_src1_tag;
  assign issue_src2_tag = pick_mul ? mul_req_src2_tag : alu_req_src2_tag;
  assign issue_alu_op   = pick_mul ? ADD        : alu_req_op;
  assign issue_mul_op   = pick_mul ? mul_req_op : MUL;

  always_ff @(posedge clock) begin
    if (reset) begin
      prio_mul <= 1'b0;
      hold     <= 1'b0;
      hold_mul <= 1'b0;
    end else begin
      if (transfer) begin
        prio_mul <= !pick_mul;                        // Loser gets the next tie
      end
      hold     <= issue_valid && !issue_ready;
      hold_mul <= pick_mul;
    end
  end

  // Single winner per transfer
  a_one_grant: assert property (@(posedge clock) disable iff (reset)
    !(alu_grant && mul_grant));

  // Port contents hold until taken, relies on bank locking too
  a_issue_stable: assert property (@(posedge clock) disable iff (reset)
    (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_fu)
      && $stable(issue_tag) && $stable(issue_src1_tag) && $stable(issue_src2_tag)
      && $stable(issue_alu_op) && $stable(issue_mul_op)));

endmodule

// ==== hw/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
  input  logic                clock,
  input  logic                reset,
  // Dispatch
  input  logic                dispatch_valid,
  output logic                dispatch_ready,
  input  issue_pkg::fu_t      dispatch_fu,
  input  issue_pkg::tag_t     dispatch_tag,
  input  issue_pkg::tag_t     dispatch_src1_tag,
  input  logic                dispatch_src1_ready,
  input  issue_pkg::tag_t     dispatch_src2_tag,
  input  logic                dispatch_src2_ready,
  input  issue_pkg::alu_op_t  dispatch_alu_op,
  input  issue_pkg::mul_op_t  dispatch_mul_op,
  // CDB
  input  logic                cdb_valid,
  input  issue_pkg::tag_t     cdb_tag,
  // Issue
  output logic                issue_valid,
  input  logic                issue_ready,
  output issue_pkg::fu_t      issue_fu,
  output issue_pkg::tag_t     issue_tag,
  output issue_pkg::tag_t     issue_src1_tag,
  output issue_pkg::tag_t     issue_src2_tag,
  output issue_pkg::alu_op_t  issue_alu_op,
  output issue_pkg::mul_op_t  issue_mul_op
);

  import issue_pkg::*;

  // ALU bank to selector
  logic    alu_dispatch_ready;
  logic    alu_req_valid;
  tag_t    alu_req_tag;
  tag_t    alu_req_src1_tag;
  tag_t    alu_req_src2_tag;
  alu_op_t alu_req_op;
  logic    alu_grant;

  // Multiply bank to selector
  logic    mul_dispatch_ready;
  logic    mul_req_valid;
  tag_t    mul_req_tag;
  tag_t    mul_req_src1_tag;
  tag_t    mul_req_src2_tag;
  mul_op_t mul_req_op;
  logic    mul_grant;

  assign dispatch_ready = alu_dispatch_ready || mul_dispatch_ready;  // Only matching class can be high

  rs_bank #(
    .payload_t (alu_op_t),
    .ENTRIES   (ALU_ENTRIES),
    .BANK_FU   (FU_ALU)
  ) alu_bank (
    .clock               (clock),
    .reset               (reset),
    .dispatch_valid      (dispatch_valid),
    .dispatch_fu         (dispatch_fu),
    .bank_dispatch_ready (alu_dispatch_ready),
    .dispatch_tag        (dispatch_tag),
    .dispatch_src1_tag   (dispatch_src1_tag),
    .dispatch_src2_tag   (dispatch_src2_tag),
    .dispatch_src1_ready (dispatch_src1_ready),
    .dispatch_src2_ready (dispatch_src2_ready),
    .dispatch_payload    (dispatch_alu_op),
    .cdb_valid           (cdb_valid),
    .cdb_tag             (cdb_tag),
    .req_valid           (alu_req_valid),
    .req_tag             (alu_req_tag),
    .req_src1_tag        (alu_req_src1_tag),
    .req_src2_tag        (alu_req_src2_tag),
    .req_payload         (alu_req_op),
    .grant               (alu_grant)
  );

  rs_bank #(
    .payload_t (mul_op_t),
    .ENTRIES   (MUL_ENTRIES),
    .BANK_FU   (FU_MUL)
  ) mul_bank (
    .clock               (clock),
    .reset               (reset),
    .dispatch_valid      (dispatch_valid),
    .dispatch_fu         (dispatch_fu),
    .bank_dispatch_ready (mul_dispatch_ready),
    .dispatch_tag        (dispatch_tag),
    .dispatch_src1_tag   (dispatch_src1_tag),
    .dispatch_src2_tag   (dispatch_src2_tag),
    .dispatch_src1_ready (dispatch_src1_ready),
    .dispatch_src2_ready (dispatch_src2_ready),
    .dispatch_payload    (dispatch_mul_op),
    .cdb_valid           (cdb_valid),
    .cdb_tag             (cdb_tag),
    .req_valid           (mul_req_valid),
    .req_tag             (mul_req_tag),
    .req_src1_tag        (mul_req_src1_tag),
    .req_src2_tag        (mul_req_src2_tag),
    .req_payload         (mul_req_op),
    .grant               (mul_grant)
  );

  issue_select select (
    .clock            (clock),
    .reset            (reset),
    .alu_req_valid    (alu_req_valid),
    .alu_req_tag      (alu_req_tag),
    .alu_req_src1_tag (alu_req_src1_tag),
    .alu_req_src2_tag (alu_req_src2_tag),
    .alu_req_op       (alu_req_op),
    .mul_req_valid    (mul_req_valid),
    .mul_req_tag      (mul_req_tag),
    .mul_req_src1_tag (mul_req_src1_tag),
    .mul_req_src2_tag (mul_req_src2_tag),
    .mul_req_op       (mul_req_op),
    .alu_grant        (alu_grant),
    .mul_grant        (mul_grant),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .issue_fu         (issue_fu),
    .issue_tag        (issue_tag),
    .issue_src1_tag   (issue_src1_tag),
    .issue_src2_tag   (issue_src2_tag),
    .issue_alu_op     (issue_alu_op),
    .issue_mul_op     (issue_mul_op)
  );

endmodule

// ==== verification/issue_scoreboard.svh ====
`ifndef ISSUE_SCOREBOARD_SVH
`define ISSUE_SCOREBOARD_SVH

// Expected contents of one issue transfer
typedef struct packed {
  fu_t     fu;
  tag_t    src1;
  tag_t    src2;
  alu_op_t alu_op;
  mul_op_t mul_op;
} issue_fields_t;

// Per-tag record of accepted instructions
logic    in_flight   [NUM_TAGS];                // Accepted, not yet issued
logic    bcast_done  [NUM_TAGS];                // Value of this tag is available
fu_t     sb_fu       [NUM_TAGS];
tag_t    sb_src1     [NUM_TAGS];
tag_t    sb_src2     [NUM_TAGS];
logic    sb_src1_rdy [NUM_TAGS];                // Ready bit given at dispatch
logic    sb_src2_rdy [NUM_TAGS];
alu_op_t sb_alu_op   [NUM_TAGS];
mul_op_t sb_mul_op   [NUM_TAGS];
int      sb_cycle    [NUM_TAGS];                // Cycle of acceptance

// Issue fields for a recorded tag, unused opcode field zero
function automatic issue_fields_t expected_issue(tag_t t);
  issue_fields_t e;
  e.fu     = sb_fu[t];
  e.src1   = sb_src1[t];
  e.src2   = sb_src2[t];
  e.alu_op = (sb_fu[t] == FU_ALU) ? sb_alu_op[t] : ADD;
  e.mul_op = (sb_fu[t] == FU_MUL) ? sb_mul_op[t] : MUL;
  return e;
endfunction

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_tag(string name, tag_t got, tag_t exp);
  if (got !== exp) begin
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_fu(string name, fu_t got, fu_t exp);
  if (got !== exp) begin
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_alu_op(string name, alu_op_t got, alu_op_t exp);
  if (got !== exp) begin
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_mul_op(string name, mul_op_t got, mul_op_t exp);
  if (got !== exp) begin
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    stop_on_failure();
  end
endtask

`endif

// ==== verification/issue_stage_tb.sv ====
`timescale 1ns/1ps

module issue_stage_tb;
  import issue_pkg::*;

  localparam int NUM_TAGS    = 1 << TAG_WIDTH;
  localparam int NUM_RANDOM  = 200;
  localparam int CYCLE_LIMIT = NUM_RANDOM * 40;           // About 40 cycles per instruction
  localparam int NUM_TOTAL   = NUM_RANDOM + ALU_ENTRIES + MUL_ENTRIES;

  logic    clock;
  logic    reset;
  logic    dispatch_valid;
  logic    dispatch_ready;
  fu_t     dispatch_fu;
  tag_t    dispatch_tag;
  tag_t    dispatch_src1_tag;
  logic    dispatch_src1_ready;
  tag_t    dispatch_src2_tag;
  logic    dispatch_src2_ready;
  alu_op_t dispatch_alu_op;
  mul_op_t dispatch_mul_op;
  logic    cdb_valid;
  tag_t    cdb_tag;
  logic    issue_valid;
  logic    issue_ready;
  fu_t     issue_fu;
  tag_t    issue_tag;
  tag_t    issue_src1_tag;
  tag_t    issue_src2_tag;
  alu_op_t issue_alu_op;
  mul_op_t issue_mul_op;

  int          cyc;                                       // Cycles since reset release
  int          accepted_count;
  int          issued_count;
  int          inflight_count;
  logic        exec_enable;                               // Execution side takes issues
  logic [31:0] stim_state;
  logic [31:0] exec_state;
  logic [31:0] delay_state;
  tag_t        free_list [$];                             // Tags free for destinations
  tag_t        recent [$];                                // Last accepted tags
  tag_t        exec_tag [$];                              // Issued, waiting for CDB
  int          exec_due [$];

  `include "issue_scoreboard.svh"

  issue_stage DUT (.*);

  always #10 clock = ~clock;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_failure();
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  // Free tags are always broadcast, recent ones may be pending
  function automatic tag_t pick_source(logic from_free);
    stim_state = xorshift(stim_state);
    if (from_free || recent.size() == 0) begin
      return free_list[stim_state[15:0] % free_list.size()];
    end
    return recent[stim_state[15:0] % recent.size()];
  endfunction

  // Drive one instruction and hold it until accepted
  task automatic dispatch_one(fu_t fu, logic ready_srcs);
    tag_t s1;
    tag_t s2;
    @(posedge clock);
    #1;
    if (free_list.size() == 0) begin
      $display("No free destination tag left");
      stop_on_failure();
    end
    s1 = pick_source(ready_srcs);
    s2 = pick_source(ready_srcs);
    stim_state          = xorshift(stim_state);
    dispatch_valid      = 1'b1;
    dispatch_fu         = fu;
    dispatch_tag        = free_list.pop_front();
    dispatch_src1_tag   = s1;
    dispatch_src2_tag   = s2;
    dispatch_src1_ready = bcast_done[s1];
    dispatch_src2_ready = bcast_done[s2];
    dispatch_alu_op     = alu_op_t'(stim_state[10:8]);
    dispatch_mul_op     = mul_op_t'(stim_state[12:11]);
    while (1) begin
      @(negedge clock);
      if (dispatch_ready) break;
      @(posedge clock);
      #1;
      dispatch_src1_ready = bcast_done[s1];               // Catch broadcasts while stalled
      dispatch_src2_ready = bcast_done[s2];
    end
  endtask

  // Execution side, one CDB tag per cycle
  always @(posedge clock) begin
    #1;
    cdb_valid   = 1'b0;
    issue_ready = 1'b0;
    if (exec_enable) begin
      exec_state  = xorshift(exec_state);
      issue_ready = (exec_state[1:0] != 2'b00);           // Stall one cycle in four
      for (int i = 0; i < exec_tag.size(); i++) begin
        if (exec_due[i] <= cyc + 1) begin
          cdb_valid = 1'b1;
          cdb_tag   = exec_tag[i];
          exec_tag.delete(i);
          exec_due.delete(i);
          break;
        end
      end
    end
  end

  // Compare process, samples mid-cycle
  always @(negedge clock) begin
    issue_fields_t exp_f;
    if (!reset) begin
      cyc = cyc + 1;
      if (cyc > CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles with %0d in flight", cyc, inflight_count);
        stop_on_failure();
      end
      if (cdb_valid) begin
        bcast_done[cdb_tag] = 1'b1;                       // Counts for this cycle's issue
        free_list.push_back(cdb_tag);
      end
      if (dispatch_valid && dispatch_ready) begin
        in_flight[dispatch_tag]   = 1'b1;
        bcast_done[dispatch_tag]  = 1'b0;                 // New producer owns the tag
        sb_fu[dispatch_tag]       = dispatch_fu;
        sb_src1[dispatch_tag]     = dispatch_src1_tag;
        sb_src2[dispatch_tag]     = dispatch_src2_tag;
        sb_src1_rdy[dispatch_tag] = dispatch_src1_ready;
        sb_src2_rdy[dispatch_tag] = dispatch_src2_ready;
        sb_alu_op[dispatch_tag]   = dispatch_alu_op;
        sb_mul_op[dispatch_tag]   = dispatch_mul_op;
        sb_cycle[dispatch_tag]    = cyc;
        accepted_count = accepted_count + 1;
        inflight_count = inflight_count + 1;
        recent.push_back(dispatch_tag);
        if (recent.size() > 8) begin
          void'(recent.pop_front());
        end
      end
      if (issue_valid && issue_ready) begin
        if (!in_flight[issue_tag]) begin
          $display("Issued tag 0x%h is unknown or issued twice", issue_tag);
          stop_on_failure();
        end
        if (cyc <= sb_cycle[issue_tag]) begin
          $display("Tag 0x%h issued in its own dispatch cycle", issue_tag);
          stop_on_failure();
        end
        exp_f = expected_issue(issue_tag);
        check_fu("issue_fu", issue_fu, exp_f.fu);
        check_tag("issue_src1_tag", issue_src1_tag, exp_f.src1);
        check_tag("issue_src2_tag", issue_src2_tag, exp_f.src2);
        check_alu_op("issue_alu_op", issue_alu_op, exp_f.alu_op);
        check_mul_op("issue_mul_op", issue_mul_op, exp_f.mul_op);
        if ((!sb_src1_rdy[issue_tag] && !bcast_done[exp_f.src1])
            || (!sb_src2_rdy[issue_tag] && !bcast_done[exp_f.src2])) begin
          $display("Tag 0x%h issued before its source was broadcast", issue_tag);
          stop_on_failure();
        end
        in_flight[issue_tag] = 1'b0;
        issued_count   = issued_count + 1;
        inflight_count = inflight_count - 1;
        delay_state    = xorshift(delay_state);
        exec_tag.push_back(issue_tag);
        exec_due.push_back(cyc + 1 + int'(delay_state[1:0]));  // 1 to 4 cycles
      end
    end
  end

  initial begin
    fu_t     held_fu;
    tag_t    held_tag;
    tag_t    held_src1;
    tag_t    held_src2;
    alu_op_t held_alu;
    mul_op_t held_mul;
    clock = 1'b0;
    reset = 1'b1;
    dispatch_valid      = 1'b0;
    dispatch_fu         = FU_ALU;
    dispatch_tag        = '0;
    dispatch_src1_tag   = '0;
    dispatch_src1_ready = 1'b0;
    dispatch_src2_tag   = '0;
    dispatch_src2_ready = 1'b0;
    dispatch_alu_op     = ADD;
    dispatch_mul_op     = MUL;
    cdb_valid      = 1'b0;
    cdb_tag        = '0;
    issue_ready    = 1'b0;
    exec_enable    = 1'b0;
    cyc            = 0;
    accepted_count = 0;
    issued_count   = 0;
    inflight_count = 0;
    stim_state     = 32'hb533_ccfc;
    exec_state     = xorshift(stim_state);
    delay_state    = xorshift(exec_state);
    for (int t = 0; t < NUM_TAGS; t++) begin
      in_flight[t]  = 1'b0;
      bcast_done[t] = 1'b1;                               // Architectural values at start
      free_list.push_back(tag_t'(t));
    end
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;

    repeat (5) begin                                      // Idle port after reset
      @(negedge clock);
      check_bit("issue_valid", issue_valid, 1'b0);
    end

    repeat (ALU_ENTRIES) dispatch_one(FU_ALU, 1'b1);      // Port stalled, ALU bank fills
    @(posedge clock);
    #1 dispatch_valid = 1'b0;
    @(negedge clock);
    check_bit("dispatch_ready", dispatch_ready, 1'b0);
    @(posedge clock);
    #1 dispatch_fu = FU_MUL;
    @(negedge clock);
    check_bit("dispatch_ready", dispatch_ready, 1'b1);
    repeat (MUL_ENTRIES) dispatch_one(FU_MUL, 1'b1);
    @(posedge clock);
    #1 dispatch_valid = 1'b0;
    @(negedge clock);
    check_bit("dispatch_ready", dispatch_ready, 1'b0);

    check_bit("issue_valid", issue_valid, 1'b1);          // Port must hold under stall
    held_fu   = issue_fu;
    held_tag  = issue_tag;
    held_src1 = issue_src1_tag;
    held_src2 = issue_src2_tag;
    held_alu  = issue_alu_op;
    held_mul  = issue_mul_op;
    repeat (4) begin
      @(negedge clock);
      check_bit("issue_valid", issue_valid, 1'b1);
      check_fu("issue_fu", issue_fu, held_fu);
      check_tag("issue_tag", issue_tag, held_tag);
      check_tag("issue_src1_tag", issue_src1_tag, held_src1);
      check_tag("issue_src2_tag", issue_src2_tag, held_src2);
      check_alu_op("issue_alu_op", issue_alu_op, held_alu);
      check_mul_op("issue_mul_op", issue_mul_op, held_mul);
    end
    exec_enable = 1'b1;

    repeat (NUM_RANDOM) begin                             // Mixed stream, about a quarter MUL
      stim_state = xorshift(stim_state);
      dispatch_one((stim_state[1:0] == 2'b00) ? FU_MUL : FU_ALU, 1'b0);
    end
    @(posedge clock);
    #1 dispatch_valid = 1'b0;
    while (inflight_count != 0) @(negedge clock);

    if (accepted_count == NUM_TOTAL && issued_count == accepted_count) begin
      $display("Testbench passed");
    end else begin
      $display("Accepted %0d and issued %0d, expected %0d each",
               accepted_count, issued_count, NUM_TOTAL);
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verification
hw/issue_pkg.sv
hw/rs_bank.sv
hw/issue_select.sv
hw/issue_stage.sv
verification/issue_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module issue_stage_tb \
  --Mdir obj_dir -o issue_stage_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/issue_stage_sim > sim.log 2>&1

grep -q "^Testbench passed$" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }
